// File: Makefile
TOP = tb_stack_cpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: flist.f
hw/stk_pkg.sv
hw/insn_decode.sv
hw/stack_alu.sv
hw/operand_stack.sv
hw/mem_port.sv
hw/seq_ctrl.sv
hw/stack_cpu.sv
tests/stack_cpu_sva.sv
tests/tb_stack_cpu.sv

// File: hw/insn_decode.sv
`timescale 1ns/1ps

module insn_decode import stk_pkg::*; (
  input  insn_u insn,
  output ctrl_t ctrl
);

  always_comb begin
    // unknown opcodes fall through as a no-op
    ctrl = '0;
    case (insn.imm_view.opcode)
      op_push: begin
        ctrl.imm  = 1'b1;
        ctrl.load = ld_alu;
        ctrl.push = 1'b1;
      end
      op_pop: begin
        ctrl.load = ld_stack1;
        ctrl.pop  = 1'b1;
      end
      op_dup: begin
        // bit 0 picks entry 0 or entry 1
        ctrl.load = load_sel_e'({1'b0, insn.imm_view.imm8[0]});
        ctrl.push = 1'b1;
      end
      op_ld: begin
        ctrl.imm  = 1'b1;
        ctrl.load = ld_rd_data;
        ctrl.rd   = 1'b1;
        ctrl.push = 1'b1;
      end
      op_ldd: begin
        // address popped, word pushed in its place
        ctrl.load = ld_rd_data;
        ctrl.rd   = 1'b1;
        ctrl.pop  = 1'b1;
        ctrl.push = 1'b1;
      end
      op_st: begin
        ctrl.imm  = 1'b1;
        ctrl.load = ld_stack1;
        ctrl.wr   = 1'b1;
        ctrl.pop  = 1'b1;
      end
      op_sta: begin
        // address stays on top
        ctrl.load = ld_keep;
        ctrl.wr   = 1'b1;
        ctrl.pop  = 1'b1;
      end
      op_std: begin
        // value stays on top
        ctrl.load = ld_stack1;
        ctrl.wr   = 1'b1;
        ctrl.pop  = 1'b1;
      end
      op_jmp: begin
        ctrl.imm = 1'b1;
        ctrl.jmp = jmp_always;
      end
      op_jz: begin
        // tested value is popped either way
        ctrl.imm  = 1'b1;
        ctrl.load = ld_stack1;
        ctrl.pop  = 1'b1;
        ctrl.jmp  = jmp_if_zero;
      end
      op_alu: begin
        ctrl.load = ld_alu;
        ctrl.pop  = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

// File: hw/mem_port.sv
`timescale 1ns/1ps

module mem_port import stk_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  ctrl_t             ctrl,
  input  logic [data_w-1:0] alu_out,
  input  logic [data_w-1:0] s0,
  input  logic [data_w-1:0] s1,
  output logic              mem_req,
  output mem_req_t          mem_cmd,
  input  logic              mem_ack,
  input  logic [data_w-1:0] mem_rdata,
  output logic [data_w-1:0] rd_word,
  output logic              done
);

  // four-phase states
  typedef enum logic [1:0] {
    mp_idle = 2'd0,
    mp_req  = 2'd1,
    mp_wait = 2'd2
  } mp_state_e;

  mp_state_e state;

  // one cycle only, state leaves mp_wait with it
  assign done = (state == mp_wait) && !mem_ack;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= mp_idle;
      mem_req <= 1'b0;
    end else begin
      case (state)
        mp_idle: if (start) begin
          state   <= mp_req;
          mem_req <= 1'b1;
        end
        mp_req: if (mem_ack) begin
          state   <= mp_wait;
          mem_req <= 1'b0;
        end
        // wait for responder to release ack
        mp_wait: if (!mem_ack) state <= mp_idle;
        default: state <= mp_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    // command held stable for the whole transfer
    if (state == mp_idle && start) begin
      mem_cmd.we    <= ctrl.wr;
      mem_cmd.addr  <= alu_out[addr_w-1:0];
      mem_cmd.wdata <= ctrl.imm ? s0 : s1;
    end
    // read word valid while ack is high
    if (state == mp_req && mem_ack && !mem_cmd.we) begin
      rd_word <= mem_rdata;
    end
  end

endmodule

// File: hw/operand_stack.sv
`timescale 1ns/1ps

module operand_stack import stk_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              update,
  input  ctrl_t             ctrl,
  input  logic [data_w-1:0] alu_out,
  input  logic [data_w-1:0] rd_word,
  output logic [data_w-1:0] s0,
  output logic [data_w-1:0] s1
);

  // entry 0 is the top
  logic [stack_depth-1:0][data_w-1:0] stk;
  logic [data_w-1:0]                  top_next;

  assign s0 = stk[0];
  assign s1 = stk[1];

  // new top from load select
  always_comb begin
    case (ctrl.load)
      ld_keep:    top_next = stk[0];
      ld_stack1:  top_next = stk[1];
      ld_alu:     top_next = alu_out;
      ld_rd_data: top_next = rd_word;
      default:    top_next = stk[0];
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stk <= '0;
    end else if (update) begin
      stk[0] <= top_next;
      if (ctrl.push && !ctrl.pop) begin
        // shift down, bottom entry falls off
        for (int i = 1; i < stack_depth; i++) begin
          stk[i] <= stk[i-1];
        end
      end else if (ctrl.pop && !ctrl.push) begin
        // shift up
        for (int i = 1; i < stack_depth - 1; i++) begin
          stk[i] <= stk[i+1];
        end
        // bottom keeps its old value
      end
    end
  end

endmodule

// File: hw/seq_ctrl.sv
`timescale 1ns/1ps

module seq_ctrl import stk_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  ctrl_t             ctrl,
  input  insn_u             insn,
  input  logic [data_w-1:0] s0,
  input  logic              done,
  output logic              start,
  output logic              update,
  output logic [pc_w-1:0]   pc,
  output logic              halted
);

  typedef enum logic [1:0] {
    ph_exec   = 2'd0,
    ph_mem    = 2'd1,
    ph_update = 2'd2
  } phase_e;

  phase_e          phase;
  logic            mem_op;
  logic            is_halt;
  logic            take_jump;
  logic            halted_q;
  logic [pc_w-1:0] imm_sext;

  assign mem_op  = ctrl.rd | ctrl.wr;
  assign is_halt = (insn == halt_word);

  // request goes out as mem is entered
  assign start  = (phase == ph_exec) && mem_op;
  assign update = (phase == ph_update);

  // relative offset, signed byte
  assign imm_sext = {{(pc_w-8){insn.imm_view.imm8[7]}}, insn.imm_view.imm8};

  // zero test on the top before any pop
  assign take_jump = (ctrl.jmp == jmp_always) ||
                     ((ctrl.jmp == jmp_if_zero) && (s0 == '0));

  // visible already in the first halt update cycle
  assign halted = halted_q | (update && is_halt);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase <= ph_exec;
    end else begin
      case (phase)
        ph_exec: phase <= ph_mem;
        // no access means a single mem cycle
        ph_mem: if (!mem_op || done) phase <= ph_update;
        ph_update: phase <= ph_exec;
        default: phase <= ph_exec;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (update && !is_halt) begin
      if (take_jump) begin
        pc <= pc + imm_sext;
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

  // sticky until reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      halted_q <= 1'b0;
    end else if (update && is_halt) begin
      halted_q <= 1'b1;
    end
  end

endmodule

// File: hw/stack_alu.sv
`timescale 1ns/1ps

module stack_alu import stk_pkg::*; (
  input  ctrl_t             ctrl,
  input  insn_u             insn,
  input  logic [data_w-1:0] s0,
  input  logic [data_w-1:0] s1,
  output logic [data_w-1:0] alu_out
);

  // comparison results, widened below
  logic lt;
  logic eq;

  assign lt = (s0 < s1);
  assign eq = (s0 == s1);

  always_comb begin
    if (ctrl.imm) begin
      // immediate path, also the address for LD and ST
      alu_out = {{(data_w-8){1'b0}}, insn.imm_view.imm8};
    end else begin
      case (insn.fn_view.fn)
        fn_s0:   alu_out = s0;
        fn_s1:   alu_out = s1;
        fn_add:  alu_out = s0 + s1;
        fn_sub:  alu_out = s0 - s1;
        // low half of the product only
        fn_mul:  alu_out = s0 * s1;
        fn_join: alu_out = s0 | (s1 << 8);
        fn_and:  alu_out = s0 & s1;
        fn_lt:   alu_out = {{(data_w-1){1'b0}}, lt};
        fn_eq:   alu_out = {{(data_w-1){1'b0}}, eq};
        fn_neq:  alu_out = {{(data_w-1){1'b0}}, ~eq};
        default: alu_out = '0;
      endcase
    end
  end

endmodule

// File: hw/stack_cpu.sv
`timescale 1ns/1ps

module stack_cpu import stk_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  insn_u             insn,
  output logic [pc_w-1:0]   pc,
  output logic              mem_req,
  output mem_req_t          mem_cmd,
  input  logic              mem_ack,
  input  logic [data_w-1:0] mem_rdata,
  output logic [data_w-1:0] tos,
  output logic              halted
);

  ctrl_t             ctrl;
  logic [data_w-1:0] s0;
  logic [data_w-1:0] s1;
  logic [data_w-1:0] alu_out;
  logic [data_w-1:0] rd_word;
  logic              start;
  logic              update;
  logic              done;

  assign tos = s0;

  insn_decode u_decode (
    .insn (insn),
    .ctrl (ctrl)
  );

  // also forms the data address
  stack_alu u_alu (
    .ctrl    (ctrl),
    .insn    (insn),
    .s0      (s0),
    .s1      (s1),
    .alu_out (alu_out)
  );

  operand_stack u_stack (
    .clk     (clk),
    .rst     (rst),
    .update  (update),
    .ctrl    (ctrl),
    .alu_out (alu_out),
    .rd_word (rd_word),
    .s0      (s0),
    .s1      (s1)
  );

  mem_port u_mem (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .ctrl      (ctrl),
    .alu_out   (alu_out),
    .s0        (s0),
    .s1        (s1),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .rd_word   (rd_word),
    .done      (done)
  );

  // phases, pc and halt
  seq_ctrl u_seq (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .insn   (insn),
    .s0     (s0),
    .done   (done),
    .start  (start),
    .update (update),
    .pc     (pc),
    .halted (halted)
  );

endmodule

// File: hw/stk_pkg.sv
package stk_pkg;

  // datapath widths
  localparam int data_w = 16;
  localparam int pc_w = 10;
  localparam int addr_w = 8;
  localparam int op_w = 8;
  localparam int stack_depth = 8;

  // opcodes in the upper instruction byte
  localparam logic [op_w-1:0] op_push = 8'h00;
  localparam logic [op_w-1:0] op_pop = 8'h01;
  localparam logic [op_w-1:0] op_dup = 8'h02;
  localparam logic [op_w-1:0] op_ld = 8'h08;
  localparam logic [op_w-1:0] op_ldd = 8'h09;
  localparam logic [op_w-1:0] op_st = 8'h0C;
  localparam logic [op_w-1:0] op_sta = 8'h0D;
  localparam logic [op_w-1:0] op_std = 8'h0E;
  localparam logic [op_w-1:0] op_jmp = 8'h10;
  localparam logic [op_w-1:0] op_jz = 8'h11;
  localparam logic [op_w-1:0] op_alu = 8'h20;
  // whole word, not just the opcode
  localparam logic [data_w-1:0] halt_word = 16'hFFFF;

  // alu function selects, lower byte of the alu group
  localparam logic [7:0] fn_s0 = 8'h00;
  localparam logic [7:0] fn_s1 = 8'h01;
  localparam logic [7:0] fn_add = 8'h02;
  localparam logic [7:0] fn_sub = 8'h03;
  localparam logic [7:0] fn_mul = 8'h04;
  localparam logic [7:0] fn_join = 8'h05;
  localparam logic [7:0] fn_and = 8'h06;
  localparam logic [7:0] fn_lt = 8'h08;
  localparam logic [7:0] fn_eq = 8'h09;
  localparam logic [7:0] fn_neq = 8'h0A;

  // lower byte as immediate
  typedef struct packed {
    logic [op_w-1:0] opcode;
    logic [7:0]      imm8;
  } imm_view_t;

  // lower byte as alu function select
  typedef struct packed {
    logic [op_w-1:0] opcode;
    logic [7:0]      fn;
  } fn_view_t;

  // ctrl.imm tells which view holds
  typedef union packed {
    imm_view_t imm_view;
    fn_view_t  fn_view;
  } insn_u;

  // source of the new top of stack
  typedef enum logic [1:0] {
    ld_keep    = 2'd0,
    ld_stack1  = 2'd1,
    ld_alu     = 2'd2,
    ld_rd_data = 2'd3
  } load_sel_e;

  typedef enum logic [1:0] {
    jmp_none    = 2'd0,
    jmp_always  = 2'd1,
    jmp_if_zero = 2'd2
  } jmp_e;

  typedef struct packed {
    logic      imm;
    load_sel_e load;
    logic      rd;
    logic      wr;
    logic      pop;
    logic      push;
    jmp_e      jmp;
  } ctrl_t;

  typedef struct packed {
    logic              we;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } mem_req_t;

endpackage

// File: tests/stack_cpu_sva.sv
`timescale 1ns/1ps

module stack_cpu_sva import stk_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic            mem_req,
  input mem_req_t        mem_cmd,
  input logic            mem_ack,
  input logic [pc_w-1:0] pc,
  input logic            update,
  input logic            halted
);

  // command frozen for the whole request
  a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_req && $past(mem_req)) |-> (mem_cmd == $past(mem_cmd)))
    else $error("mem_cmd changed while mem_req was high");

  // previous transfer must be fully closed
  a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) |-> !mem_ack)
    else $error("mem_req rose while mem_ack was still high");

  // pc moves only on the update edge
  a_pc_update: assert property (@(posedge clk) disable iff (rst)
    (pc != $past(pc)) |-> $past(update))
    else $error("pc changed outside the update phase");

  a_pc_halted: assert property (@(posedge clk) disable iff (rst)
    $past(halted) |-> (pc == $past(pc)))
    else $error("pc changed while halted");

endmodule

// core top sees both the port and sequencer signals
bind stack_cpu stack_cpu_sva sva0 (
  .clk     (clk),
  .rst     (rst),
  .mem_req (mem_req),
  .mem_cmd (mem_cmd),
  .mem_ack (mem_ack),
  .pc      (pc),
  .update  (update),
  .halted  (halted)
);

// File: tests/tb_stack_cpu.sv
`timescale 1ns/1ps

module tb_stack_cpu import stk_pkg::*; ();

  logic              clk;
  logic              rst;
  insn_u             insn;
  logic [pc_w-1:0]   pc;
  logic              mem_req;
  mem_req_t          mem_cmd;
  logic              mem_ack = 1'b0;
  logic [data_w-1:0] mem_rdata = '0;
  logic [data_w-1:0] tos;
  logic              halted;

  // program store, data memory, model state
  logic [data_w-1:0] pmem [0:(1<<pc_w)-1];
  logic [data_w-1:0] dmem [0:255];
  logic [data_w-1:0] m_mem [0:255];
  logic [data_w-1:0] m_stk [0:stack_depth-1];
  logic [pc_w-1:0]   m_pc;
  logic [data_w-1:0] m_rd;
  logic              m_had_rd;
  logic [data_w-1:0] prog [$];
  logic [15:0]       lfsr;
  logic              ack_armed = 1'b0;
  logic [1:0]        ack_delay = 2'd0;
  // cycle budget of the running program, zero when idle
  int                wait_limit = 0;
  int                errs;
  int                total_errs;
  int                tests_run;
  int                tests_failed;

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  stack_cpu dut0 (
    .clk       (clk),
    .rst       (rst),
    .insn      (insn),
    .pc        (pc),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .tos       (tos),
    .halted    (halted)
  );

  // program store answers at once
  assign insn = pmem[pc];

  function automatic logic [15:0] fill_word(input logic [7:0] a);
    return {a ^ 8'h3C, ~a};
  endfunction

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // four-phase responder with 0 to 3 extra cycles before ack
  always @(posedge clk) begin
    logic [15:0] r;
    if (rst) begin
      mem_ack   <= 1'b0;
      ack_armed <= 1'b0;
      for (int a = 0; a < 256; a++) begin
        dmem[a] <= fill_word(8'(a));
      end
    end else if (!mem_req) begin
      // port released the request
      mem_ack   <= 1'b0;
      ack_armed <= 1'b0;
    end else if (!mem_ack) begin
      if (!ack_armed) begin
        take_bits(2, r);
        ack_armed <= 1'b1;
        ack_delay <= r[1:0];
      end else if (ack_delay != 2'd0) begin
        ack_delay <= ack_delay - 2'd1;
      end else begin
        mem_ack   <= 1'b1;
        mem_rdata <= dmem[mem_cmd.addr];
        if (mem_cmd.we) begin
          dmem[mem_cmd.addr] <= mem_cmd.wdata;
        end
      end
    end
  end

  // ends the run when a program overruns its cycle budget
  initial begin
    int count;
    count = 0;
    while (wait_limit == 0 || count <= wait_limit) begin
      @(posedge clk);
      if (wait_limit == 0) begin
        count = 0;
      end else begin
        count++;
      end
    end
    $display("timeout: core did not halt within %0d cycles", wait_limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [15:0] ins(input logic [7:0] op, input logic [7:0] lo);
    return {op, lo};
  endfunction

  // expected alu result with a as the top entry
  function automatic logic [15:0] ref_alu(input logic [7:0] fn, input logic [15:0] a,
                                          input logic [15:0] b);
    logic [31:0] p;
    p = a * b;
    case (fn)
      fn_s0:   return a;
      fn_s1:   return b;
      fn_add:  return a + b;
      fn_sub:  return a - b;
      fn_mul:  return p[15:0];
      fn_join: return {a[15:8] | b[7:0], a[7:0]};
      fn_and:  return a & b;
      fn_lt:   return {15'd0, a < b};
      fn_eq:   return {15'd0, a == b};
      fn_neq:  return {15'd0, a != b};
      default: return 16'h0000;
    endcase
  endfunction

  task automatic model_push(input logic [15:0] v);
    for (int i = stack_depth - 1; i > 0; i--) begin
      m_stk[i] = m_stk[i-1];
    end
    m_stk[0] = v;
  endtask

  // entry 1 removed and bottom entry kept
  task automatic model_drop1();
    for (int i = 1; i < stack_depth - 1; i++) begin
      m_stk[i] = m_stk[i+1];
    end
  endtask

  task automatic model_pop();
    logic [15:0] t;
    t = m_stk[1];
    model_drop1();
    m_stk[0] = t;
  endtask

  // walks the program from pc 0 up to the halt word
  task automatic run_model();
    logic [7:0]      op;
    logic [7:0]      lo;
    logic [15:0]     t;
    logic [pc_w-1:0] nxt;
    logic [pc_w-1:0] off;
    int              steps;
    m_pc = '0;
    m_had_rd = 1'b0;
    steps = 0;
    for (int i = 0; i < stack_depth; i++) begin
      m_stk[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      m_mem[i] = fill_word(8'(i));
    end
    while (pmem[m_pc] != halt_word && steps < 4000) begin
      op = pmem[m_pc][15:8];
      lo = pmem[m_pc][7:0];
      off = {{(pc_w-8){lo[7]}}, lo};
      nxt = m_pc + pc_w'(1);
      // alu value doubles as the address for ldd sta and std
      t = ref_alu(lo, m_stk[0], m_stk[1]);
      case (op)
        op_push: model_push({8'h00, lo});
        op_pop:  model_pop();
        op_dup:  model_push(lo[0] ? m_stk[1] : m_stk[0]);
        op_ld: begin
          m_rd = m_mem[lo];
          m_had_rd = 1'b1;
          model_push(m_rd);
        end
        op_ldd: begin
          m_rd = m_mem[t[7:0]];
          m_had_rd = 1'b1;
          m_stk[0] = m_rd;
        end
        op_st: begin
          m_mem[lo] = m_stk[0];
          model_pop();
        end
        op_sta: begin
          m_mem[t[7:0]] = m_stk[1];
          model_drop1();
        end
        op_std: begin
          m_mem[t[7:0]] = m_stk[1];
          model_pop();
        end
        op_jmp: nxt = m_pc + off;
        op_jz: begin
          if (m_stk[0] == '0) begin
            nxt = m_pc + off;
          end
          model_pop();
        end
        op_alu: begin
          model_drop1();
          m_stk[0] = t;
        end
        default: ;
      endcase
      m_pc = nxt;
      steps++;
    end
  endtask

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errs++;
    end
  endtask

  // reset held 3 cycles while the program is loaded
  task automatic load_and_reset();
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < (1 << pc_w); i++) begin
      pmem[i] = halt_word;
    end
    foreach (prog[i]) begin
      pmem[i] = prog[i];
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
  endtask

  task automatic finish_program();
    wait_limit = 40 * prog.size() + 100;
    while (!halted) begin
      @(negedge clk);
    end
    wait_limit = 0;
    run_model();
    check_val("tos", tos, m_stk[0]);
    check_val("pc", 16'(pc), 16'(m_pc));
    for (int i = 0; i < stack_depth; i++) begin
      check_val($sformatf("stk[%0d]", i), dut0.u_stack.stk[i], m_stk[i]);
    end
    if (m_had_rd) begin
      check_val("rd_word", dut0.u_mem.rd_word, m_rd);
    end
    for (int i = 0; i < 256; i++) begin
      if (dmem[i] !== m_mem[i]) begin
        $display("mismatch dmem[%02h]: got %h expected %h", i, dmem[i], m_mem[i]);
        errs++;
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errs);
      tests_failed++;
    end
    total_errs += errs;
    errs = 0;
  endtask

  task automatic test_reset();
    prog.delete();
    prog.push_back(ins(op_push, 8'h12));
    prog.push_back(halt_word);
    // halted core with a loaded stack goes into reset
    load_and_reset();
    finish_program();
    load_and_reset();
    check_val("pc", 16'(pc), 16'h0000);
    check_val("tos", tos, 16'h0000);
    check_val("mem_req", 16'(mem_req), 16'h0000);
    check_val("halted", 16'(halted), 16'h0000);
    finish_program();
    end_test("reset");
  endtask

  // nine pushes overflow the bottom and pops then pull it up
  task automatic test_stack();
    for (int n_pop = 2; n_pop <= 10; n_pop += 8) begin
      prog.delete();
      for (int i = 1; i <= 9; i++) begin
        prog.push_back(ins(op_push, 8'(i * 17)));
      end
      prog.push_back(ins(op_dup, 8'h00));
      prog.push_back(ins(op_dup, 8'h01));
      for (int i = 0; i < n_pop; i++) begin
        prog.push_back(ins(op_pop, 8'h00));
      end
      prog.push_back(halt_word);
      load_and_reset();
      finish_program();
    end
    end_test("stack");
  endtask

  task automatic test_alu();
    logic [7:0]  fns [0:10];
    logic [15:0] a;
    logic [15:0] b;
    fns = '{fn_s0, fn_s1, fn_add, fn_sub, fn_mul, fn_join, fn_and, fn_lt, fn_eq, fn_neq,
            8'h07};
    // second round with equal operands
    for (int rep = 0; rep < 2; rep++) begin
      for (int k = 0; k < 11; k++) begin
        take_bits(16, a);
        take_bits(16, b);
        if (rep == 1) begin
          b = a;
        end
        prog.delete();
        // b built first so a ends on top
        prog.push_back(ins(op_push, b[15:8]));
        prog.push_back(ins(op_push, b[7:0]));
        prog.push_back(ins(op_alu, fn_join));
        prog.push_back(ins(op_push, a[15:8]));
        prog.push_back(ins(op_push, a[7:0]));
        prog.push_back(ins(op_alu, fn_join));
        prog.push_back(ins(op_alu, fns[k]));
        prog.push_back(halt_word);
        load_and_reset();
        finish_program();
      end
    end
    end_test("alu");
  endtask

  // cut after sta, after std, and the whole program
  task automatic test_memory();
    logic [15:0] r;
    int          cuts [0:2];
    cuts = '{9, 12, 13};
    for (int c = 0; c < 3; c++) begin
      prog.delete();
      take_bits(8, r);
      prog.push_back(ins(op_push, r[7:0]));
      prog.push_back(ins(op_st, 8'h10));
      prog.push_back(ins(op_ld, 8'h10));
      prog.push_back(ins(op_ld, 8'h33));
      prog.push_back(ins(op_push, 8'h20));
      prog.push_back(ins(op_ldd, fn_s0));
      take_bits(8, r);
      prog.push_back(ins(op_push, r[7:0]));
      prog.push_back(ins(op_push, 8'h40));
      prog.push_back(ins(op_sta, fn_s0));
      take_bits(8, r);
      prog.push_back(ins(op_push, r[7:0]));
      prog.push_back(ins(op_push, 8'h41));
      prog.push_back(ins(op_std, fn_s0));
      prog.push_back(ins(op_ld, 8'h40));
      while (prog.size() > cuts[c]) begin
        void'(prog.pop_back());
      end
      prog.push_back(halt_word);
      load_and_reset();
      finish_program();
    end
    end_test("memory");
  endtask

  task automatic test_branch();
    prog.delete();
    prog.push_back(ins(op_push, 8'h03));
    prog.push_back(ins(op_jmp, 8'h03));
    prog.push_back(ins(op_push, 8'hEE));
    prog.push_back(ins(op_push, 8'hEE));
    // jz taken
    prog.push_back(ins(op_push, 8'h00));
    prog.push_back(ins(op_jz, 8'h03));
    prog.push_back(ins(op_push, 8'hDD));
    prog.push_back(ins(op_push, 8'hDD));
    // jz not taken
    prog.push_back(ins(op_push, 8'h01));
    prog.push_back(ins(op_jz, 8'h02));
    prog.push_back(ins(op_push, 8'h05));
    prog.push_back(ins(op_jmp, 8'h03));
    prog.push_back(ins(op_push, 8'h44));
    prog.push_back(halt_word);
    // backward hop to 12
    prog.push_back(ins(op_jmp, 8'hFE));
    prog.push_back(halt_word);
    load_and_reset();
    finish_program();
    end_test("branch");
  endtask

  task automatic test_halt();
    logic [pc_w-1:0] hold_pc;
    prog.delete();
    prog.push_back(ins(op_push, 8'h07));
    prog.push_back(halt_word);
    load_and_reset();
    finish_program();
    hold_pc = pc;
    repeat (20) @(negedge clk);
    check_val("pc", 16'(pc), 16'(hold_pc));
    check_val("halted", 16'(halted), 16'h0001);
    end_test("halt");
  endtask

  initial begin
    lfsr = 16'd65428;
    rst = 1'b1;
    for (int i = 0; i < (1 << pc_w); i++) begin
      pmem[i] = halt_word;
    end
    errs = 0;
    total_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    test_reset();
    test_stack();
    test_alu();
    test_memory();
    test_branch();
    test_halt();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
